// ==== hw/ps2_emu_macros.svh ====
`ifndef PS2_EMU_MACROS_SVH
`define PS2_EMU_MACROS_SVH

// log2 of the scan byte fifo depth
// 3 gives the 8 entries per device
`define PS2_FIFO_BITS 3

// ps2_clk cycles in each half of the line clock period
// a full bit on the ps2 lines lasts twice this
`define PS2_HALF_BIT 4

// wishbone register addresses
// keyboard scan byte, write only
`define PS2_ADR_KBD 0
// mouse scan byte, write only
`define PS2_ADR_MOUSE 1
// fifo status byte, read clears both overflow flags
`define PS2_ADR_STATUS 2

`endif

// ==== hw/ps2_emu_pkg.sv ====
`include "ps2_emu_macros.svh"

package ps2_emu_pkg;

	// one scan byte as sent on a ps2 line
	typedef logic [7:0] ps2_byte_t;

	// fifo pointer, msb is the wrap bit used to tell full from empty
	typedef logic [`PS2_FIFO_BITS:0] fifo_ptr_t;

	// transmitter states, one per frame section
	typedef enum logic [2:0] {
		ST_IDLE,
		ST_START,
		ST_DATA,
		ST_PARITY,
		ST_STOP,
		ST_GAP
	} tx_state_e;

	// wishbone classic request from the io controller
	typedef struct packed {
		logic      cyc;
		logic      stb;
		logic      we;
		logic [1:0] adr;
		ps2_byte_t dat;
	} wb_req_t;

	// wishbone response back to the io controller
	typedef struct packed {
		logic      ack;
		ps2_byte_t dat;
	} wb_rsp_t;

	// status byte returned on a read of the status address
	typedef struct packed {
		logic       kbd_empty;
		logic       kbd_full;
		logic       kbd_ovf;
		logic       mouse_empty;
		logic       mouse_full;
		logic       mouse_ovf;
		logic [1:0] rsvd;
	} ps2_status_t;

endpackage

// ==== hw/ps2_byte_fifo.sv ====
`timescale 1ns/100ps

`include "ps2_emu_macros.svh"

module ps2_byte_fifo (
	input  logic                   ps2_clk,
	input  logic                   SPI_SS_IO,
	input  logic                   push,
	input  ps2_emu_pkg::ps2_byte_t push_byte,
	input  logic                   pop,
	output ps2_emu_pkg::ps2_byte_t head,
	output logic                   empty,
	output logic                   full,
	output logic                   ovf,
	input  logic                   ovf_clr
);
	import ps2_emu_pkg::*;

	localparam int DEPTH = 1 << `PS2_FIFO_BITS;

	ps2_byte_t mem [DEPTH];
	fifo_ptr_t wptr;
	fifo_ptr_t rptr;

	// pointers match when empty, differ only in the wrap bit when full
	assign empty = wptr == rptr;
	assign full  = (wptr ^ rptr) == {1'b1, {`PS2_FIFO_BITS{1'b0}}};
	assign head  = mem[rptr[`PS2_FIFO_BITS-1:0]];

	// byte storage
	always_ff @(posedge ps2_clk) begin
		if (push && !full)
			mem[wptr[`PS2_FIFO_BITS-1:0]] <= push_byte;
	end

	always_ff @(posedge ps2_clk or posedge SPI_SS_IO) begin
		if (SPI_SS_IO) begin
			wptr <= '0;
			rptr <= '0;
			ovf  <= 1'b0;
		end else begin
			if (push && !full)
				wptr <= wptr + fifo_ptr_t'(1);
			if (pop && !empty)
				rptr <= rptr + fifo_ptr_t'(1);
			// a dropped byte wins over a clear in the same cycle
			if (push && full)
				ovf <= 1'b1;
			else if (ovf_clr)
				ovf <= 1'b0;
		end
	end

	// the transmitter only takes a byte that is there
	a_no_pop_empty : assert property (
		@(posedge ps2_clk) disable iff (SPI_SS_IO)
		!(pop && empty)
	);

endmodule

// ==== hw/ps2_bit_timer.sv ====
`timescale 1ns/100ps

`include "ps2_emu_macros.svh"

module ps2_bit_timer (
	input  logic ps2_clk,
	input  logic SPI_SS_IO,
	output logic line_clk,
	output logic rise_tick
);

	localparam int CNT_W = (`PS2_HALF_BIT > 1) ? $clog2(`PS2_HALF_BIT) : 1;

	logic [CNT_W-1:0] cnt;
	logic             wrap;

	// last cycle of each half period
	assign wrap = cnt == CNT_W'(`PS2_HALF_BIT - 1);

	// wrap while low means line_clk goes high on the next edge
	assign rise_tick = wrap && !line_clk;

	always_ff @(posedge ps2_clk or posedge SPI_SS_IO) begin
		if (SPI_SS_IO) begin
			cnt      <= '0;
			// line clock idles high like a real device
			line_clk <= 1'b1;
		end else begin
			if (wrap) begin
				cnt      <= '0;
				line_clk <= !line_clk;
			end else begin
				cnt <= cnt + CNT_W'(1);
			end
		end
	end

endmodule

// ==== hw/ps2_frame_fsm.sv ====
`timescale 1ns/100ps

module ps2_frame_fsm (
	input  logic                   ps2_clk,
	input  logic                   SPI_SS_IO,
	input  logic                   line_clk,
	input  logic                   rise_tick,
	input  ps2_emu_pkg::ps2_byte_t head,
	input  logic                   empty,
	output logic                   pop,
	output logic                   dev_clk,
	output logic                   dev_data
);
	import ps2_emu_pkg::*;

	tx_state_e state;
	logic [2:0] bit_cnt;
	ps2_byte_t  shift;
	logic       parity;
	logic       load;
	logic       shift_en;
	logic       quiet;

	// take a byte at a line clock rise, from idle or straight out of the gap
	assign load = rise_tick && !empty && (state == ST_IDLE || state == ST_GAP);
	assign pop  = load;

	// bit 0 goes out when leaving start, bits 1 to 7 during data
	assign shift_en = rise_tick &&
		(state == ST_START || (state == ST_DATA && bit_cnt != 3'd7));

	// line clock is only passed through while a frame is on the wire
	assign quiet   = state == ST_IDLE || state == ST_GAP;
	assign dev_clk = line_clk || quiet;

	always_ff @(posedge ps2_clk or posedge SPI_SS_IO) begin
		if (SPI_SS_IO) begin
			state    <= ST_IDLE;
			bit_cnt  <= '0;
			dev_data <= 1'b1;
		end else if (load) begin
			// start bit is 0
			state    <= ST_START;
			bit_cnt  <= '0;
			dev_data <= 1'b0;
		end else if (rise_tick) begin
			unique case (state)
				ST_IDLE: begin
					state <= ST_IDLE;
				end
				ST_START: begin
					state    <= ST_DATA;
					dev_data <= shift[0];
				end
				ST_DATA: begin
					if (bit_cnt == 3'd7) begin
						// all eight bits sent, parity is complete
						state    <= ST_PARITY;
						dev_data <= parity;
					end else begin
						dev_data <= shift[0];
						bit_cnt  <= bit_cnt + 3'd1;
					end
				end
				ST_PARITY: begin
					// stop bit is 1
					state    <= ST_STOP;
					dev_data <= 1'b1;
				end
				ST_STOP: begin
					state <= ST_GAP;
				end
				ST_GAP: begin
					state <= ST_IDLE;
				end
				default: begin
					state    <= ST_IDLE;
					dev_data <= 1'b1;
				end
			endcase
		end
	end

	// shifter and odd parity
	always_ff @(posedge ps2_clk) begin
		if (load) begin
			shift  <= head;
			parity <= 1'b1;
		end else if (shift_en) begin
			shift  <= {1'b0, shift[7:1]};
			parity <= parity ^ shift[0];
		end
	end

	// the stop bit leaves the data line high for the idle state
	a_idle_data_high : assert property (
		@(posedge ps2_clk) disable iff (SPI_SS_IO)
		(state == ST_IDLE) |-> dev_data
	);

endmodule

// ==== hw/ps2_wb_regs.sv ====
`timescale 1ns/100ps

`include "ps2_emu_macros.svh"

module ps2_wb_regs (
	input  logic                     ps2_clk,
	input  logic                     SPI_SS_IO,
	input  ps2_emu_pkg::wb_req_t     wb_req,
	output ps2_emu_pkg::wb_rsp_t     wb_rsp,
	output logic                     kbd_push,
	output logic                     mouse_push,
	output ps2_emu_pkg::ps2_byte_t   push_byte,
	input  ps2_emu_pkg::ps2_status_t status,
	output logic                     ovf_clr
);
	import ps2_emu_pkg::*;

	logic      ack_q;
	ps2_byte_t rd_q;
	logic      cyc_new;
	logic      is_kbd;
	logic      is_mouse;
	logic      is_stat;

	// a classic cycle is new only while the previous one is not being acked
	assign cyc_new = wb_req.cyc && wb_req.stb && !ack_q;

	// anything outside the three used addresses is acked and ignored
	assign is_kbd   = wb_req.adr == 2'(`PS2_ADR_KBD);
	assign is_mouse = wb_req.adr == 2'(`PS2_ADR_MOUSE);
	assign is_stat  = wb_req.adr == 2'(`PS2_ADR_STATUS);

	// all control strobes line up with ack
	always_ff @(posedge ps2_clk or posedge SPI_SS_IO) begin
		if (SPI_SS_IO) begin
			ack_q      <= 1'b0;
			rd_q       <= '0;
			kbd_push   <= 1'b0;
			mouse_push <= 1'b0;
			ovf_clr    <= 1'b0;
		end else begin
			ack_q      <= cyc_new;
			kbd_push   <= cyc_new && wb_req.we && is_kbd;
			mouse_push <= cyc_new && wb_req.we && is_mouse;
			// status read also clears the sticky overflow flags
			ovf_clr    <= cyc_new && !wb_req.we && is_stat;
			// read data is zero except for the status address
			if (cyc_new && !wb_req.we && is_stat)
				rd_q <= status;
			else
				rd_q <= '0;
		end
	end

	// byte that goes to whichever fifo gets the push
	always_ff @(posedge ps2_clk) begin
		if (cyc_new && wb_req.we)
			push_byte <= wb_req.dat;
	end

	assign wb_rsp = '{ack: ack_q, dat: rd_q};

	// one ack per classic cycle and the master has dropped stb right after it
	a_ack_single : assert property (
		@(posedge ps2_clk) disable iff (SPI_SS_IO)
		wb_rsp.ack |=> (!wb_rsp.ack && !wb_req.stb)
	);

endmodule

// ==== hw/ps2_emu_top.sv ====
`timescale 1ns/100ps

module ps2_emu_top (
	input  logic                 ps2_clk,
	input  logic                 SPI_SS_IO,
	input  ps2_emu_pkg::wb_req_t wb_req,
	output ps2_emu_pkg::wb_rsp_t wb_rsp,
	output logic                 ps2_kbd_clk,
	output logic                 ps2_kbd_data,
	output logic                 ps2_mouse_clk,
	output logic                 ps2_mouse_data
);
	import ps2_emu_pkg::*;

	logic        kbd_push;
	logic        mouse_push;
	ps2_byte_t   push_byte;
	logic        ovf_clr;
	ps2_status_t status;

	ps2_byte_t   kbd_head;
	logic        kbd_empty;
	logic        kbd_full;
	logic        kbd_ovf;
	logic        kbd_pop;

	ps2_byte_t   mouse_head;
	logic        mouse_empty;
	logic        mouse_full;
	logic        mouse_ovf;
	logic        mouse_pop;

	logic        line_clk;
	logic        rise_tick;

	// status byte seen by the io controller
	assign status = '{
		kbd_empty:   kbd_empty,
		kbd_full:    kbd_full,
		kbd_ovf:     kbd_ovf,
		mouse_empty: mouse_empty,
		mouse_full:  mouse_full,
		mouse_ovf:   mouse_ovf,
		rsvd:        2'b00
	};

	ps2_wb_regs u_regs (
		.ps2_clk   (ps2_clk),
		.SPI_SS_IO (SPI_SS_IO),
		.wb_req    (wb_req),
		.wb_rsp    (wb_rsp),
		.kbd_push  (kbd_push),
		.mouse_push(mouse_push),
		.push_byte (push_byte),
		.status    (status),
		.ovf_clr   (ovf_clr)
	);

	// keyboard channel
	ps2_byte_fifo u_kbd_fifo (
		.ps2_clk  (ps2_clk),
		.SPI_SS_IO(SPI_SS_IO),
		.push     (kbd_push),
		.push_byte(push_byte),
		.pop      (kbd_pop),
		.head     (kbd_head),
		.empty    (kbd_empty),
		.full     (kbd_full),
		.ovf      (kbd_ovf),
		.ovf_clr  (ovf_clr)
	);

	// mouse channel
	ps2_byte_fifo u_mouse_fifo (
		.ps2_clk  (ps2_clk),
		.SPI_SS_IO(SPI_SS_IO),
		.push     (mouse_push),
		.push_byte(push_byte),
		.pop      (mouse_pop),
		.head     (mouse_head),
		.empty    (mouse_empty),
		.full     (mouse_full),
		.ovf      (mouse_ovf),
		.ovf_clr  (ovf_clr)
	);

	// one line clock shared by both transmitters
	ps2_bit_timer u_timer (
		.ps2_clk  (ps2_clk),
		.SPI_SS_IO(SPI_SS_IO),
		.line_clk (line_clk),
		.rise_tick(rise_tick)
	);

	ps2_frame_fsm u_kbd_tx (
		.ps2_clk  (ps2_clk),
		.SPI_SS_IO(SPI_SS_IO),
		.line_clk (line_clk),
		.rise_tick(rise_tick),
		.head     (kbd_head),
		.empty    (kbd_empty),
		.pop      (kbd_pop),
		.dev_clk  (ps2_kbd_clk),
		.dev_data (ps2_kbd_data)
	);

	ps2_frame_fsm u_mouse_tx (
		.ps2_clk  (ps2_clk),
		.SPI_SS_IO(SPI_SS_IO),
		.line_clk (line_clk),
		.rise_tick(rise_tick),
		.head     (mouse_head),
		.empty    (mouse_empty),
		.pop      (mouse_pop),
		.dev_clk  (ps2_mouse_clk),
		.dev_data (ps2_mouse_data)
	);

endmodule

// ==== tb/ps2_clk_gen.sv ====
`timescale 1ns/100ps

module ps2_clk_gen #(
	parameter int PERIOD_NS    = 8,
	parameter int RESET_CYCLES = 2
) (
	output logic ps2_clk,
	output logic SPI_SS_IO
);

	// free running system clock
	initial begin
		ps2_clk = 1'b0;
		forever #(PERIOD_NS / 2) ps2_clk = ~ps2_clk;
	end

	// reset high from time zero, released on a falling edge
	initial begin
		SPI_SS_IO = 1'b1;
		repeat (RESET_CYCLES) @(posedge ps2_clk);
		@(negedge ps2_clk);
		SPI_SS_IO = 1'b0;
	end

endmodule

// ==== tb/ps2_frame_monitor.sv ====
`timescale 1ns/100ps

module ps2_frame_monitor #(
	parameter string NAME   = "ps2",
	parameter int    BIT_NS = 64
) (
	input  logic                   dev_clk,
	input  logic                   dev_data,
	output ps2_emu_pkg::ps2_byte_t last_byte,
	output int                     frames,
	output logic                   fmt_err
);
	import ps2_emu_pkg::*;

	// one real falling edge of the device clock
	// a zero width low pulse is skipped, data is taken while clk is low
	task automatic wait_fall(output logic b, output realtime t);
		logic seen;
		seen = 1'b0;
		while (!seen) begin
			@(negedge dev_clk);
			t = $realtime;
			#1;
			seen = dev_clk === 1'b0;
		end
		b = dev_data;
	endtask

	task automatic report_bit(input string what, input logic got, input logic want);
		$display("error %s_data %s: got 0x%0h expected 0x%0h", NAME, what, got, want);
		fmt_err = 1'b1;
	endtask

	initial begin : decode
		logic [10:0] bits;
		logic        b;
		realtime     t_prev;
		realtime     t_now;
		int          dt;
		last_byte = '0;
		frames    = 0;
		fmt_err   = 1'b0;
		forever begin
			// first fall after idle is the start bit
			wait_fall(b, t_prev);
			bits = {b, 10'b0};
			repeat (10) begin
				wait_fall(b, t_now);
				dt = $rtoi(t_now - t_prev);
				// every bit lasts one line period
				assert (dt == BIT_NS) else begin
					$display("error %s_clk bit period: got 0x%0h ns expected 0x%0h ns",
						NAME, dt, BIT_NS);
					fmt_err = 1'b1;
				end
				bits   = {b, bits[10:1]};
				t_prev = t_now;
			end
			// bits[0] start, bits[8:1] data lsb first, bits[9] parity, bits[10] stop
			assert (bits[0] == 1'b0) else report_bit("start bit", bits[0], 1'b0);
			// odd parity, data and parity bit together hold an odd count of ones
			assert (bits[9] == ~^bits[8:1]) else report_bit("parity bit", bits[9], ~^bits[8:1]);
			assert (bits[10] == 1'b1) else report_bit("stop bit", bits[10], 1'b1);
			if (!fmt_err) begin
				last_byte = bits[8:1];
				frames    = frames + 1;
			end
		end
	end

endmodule

// ==== tb/ps2_emu_tb.sv ====
`timescale 1ns/100ps

`include "ps2_emu_macros.svh"

module ps2_emu_tb;
	import ps2_emu_pkg::*;

	localparam int CLK_NS     = 8;
	localparam int LINE_CYC   = 2 * `PS2_HALF_BIT;
	localparam int BIT_NS     = LINE_CYC * CLK_NS;
	localparam int FIFO_DEPTH = 1 << `PS2_FIFO_BITS;
	localparam logic [31:0] SEED = 32'h8eef_c4fe;
	// every byte written, the ignored and dropped ones included
	localparam int BYTES_SENT = 1 + 1 + 8 + 1 + FIFO_DEPTH + 2;
	// eleven frame bits and a gap per byte, plus room for register traffic
	localparam int WATCHDOG_NS = (BYTES_SENT * 12 * LINE_CYC + 200) * CLK_NS;

	logic        ps2_clk;
	logic        SPI_SS_IO;
	wb_req_t     wb_req;
	wb_rsp_t     wb_rsp;
	logic        ps2_kbd_clk;
	logic        ps2_kbd_data;
	logic        ps2_mouse_clk;
	logic        ps2_mouse_data;
	ps2_byte_t   kbd_byte;
	ps2_byte_t   mouse_byte;
	int          kbd_frames;
	int          mouse_frames;
	logic        kbd_err;
	logic        mouse_err;
	logic [31:0] lfsr;
	// bytes written and not yet seen on the lines
	ps2_byte_t   kbd_q[$];
	ps2_byte_t   mouse_q[$];

	ps2_clk_gen #(.PERIOD_NS(CLK_NS), .RESET_CYCLES(2)) u_clk (
		.ps2_clk  (ps2_clk),
		.SPI_SS_IO(SPI_SS_IO)
	);

	ps2_emu_top uut (
		.ps2_clk       (ps2_clk),
		.SPI_SS_IO     (SPI_SS_IO),
		.wb_req        (wb_req),
		.wb_rsp        (wb_rsp),
		.ps2_kbd_clk   (ps2_kbd_clk),
		.ps2_kbd_data  (ps2_kbd_data),
		.ps2_mouse_clk (ps2_mouse_clk),
		.ps2_mouse_data(ps2_mouse_data)
	);

	ps2_frame_monitor #(.NAME("ps2_kbd"), .BIT_NS(BIT_NS)) u_kbd_mon (
		.dev_clk  (ps2_kbd_clk),
		.dev_data (ps2_kbd_data),
		.last_byte(kbd_byte),
		.frames   (kbd_frames),
		.fmt_err  (kbd_err)
	);

	ps2_frame_monitor #(.NAME("ps2_mouse"), .BIT_NS(BIT_NS)) u_mouse_mon (
		.dev_clk  (ps2_mouse_clk),
		.dev_data (ps2_mouse_data),
		.last_byte(mouse_byte),
		.frames   (mouse_frames),
		.fmt_err  (mouse_err)
	);

	task automatic fail_run();
		$display("=== FAIL ===");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic fail_note(input string msg);
		$display("%s", msg);
		fail_run();
	endtask

	task automatic expect_bit(input string sig, input logic got, input logic want);
		assert (got === want) else begin
			$display("error %s: got 0x%0h expected 0x%0h", sig, got, want);
			fail_run();
		end
	endtask

	task automatic expect_byte(input string sig, input ps2_byte_t got, input ps2_byte_t want);
		assert (got === want) else begin
			$display("error %s: got 0x%02h expected 0x%02h", sig, got, want);
			fail_run();
		end
	endtask

	// galois form of x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return (s >> 1) ^ (s[0] ? 32'h8020_0003 : 32'h0);
	endfunction

	// one lfsr step per bit taken
	function automatic ps2_byte_t next_byte();
		ps2_byte_t b;
		b = '0;
		repeat (8) begin
			lfsr = lfsr_step(lfsr);
			b    = {b[6:0], lfsr[0]};
		end
		return b;
	endfunction

	function automatic ps2_status_t make_status(input logic ke, kf, ko, me, mf, mo);
		return '{kbd_empty: ke, kbd_full: kf, kbd_ovf: ko,
			mouse_empty: me, mouse_full: mf, mouse_ovf: mo, rsvd: 2'b00};
	endfunction

	// one classic cycle, ack must come exactly one edge later for one cycle
	task automatic wb_cycle(input logic we, input logic [1:0] adr, input ps2_byte_t wdat,
		output ps2_byte_t rdat);
		@(negedge ps2_clk);
		expect_bit("wb_rsp.ack before request", wb_rsp.ack, 1'b0);
		wb_req = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: wdat};
		@(negedge ps2_clk);
		expect_bit("wb_rsp.ack one cycle after request", wb_rsp.ack, 1'b1);
		rdat   = wb_rsp.dat;
		wb_req = '0;
		@(negedge ps2_clk);
		expect_bit("wb_rsp.ack second cycle", wb_rsp.ack, 1'b0);
	endtask

	task automatic send_byte(input logic kbd);
		ps2_byte_t b;
		ps2_byte_t rd;
		b = next_byte();
		if (kbd) begin
			wb_cycle(1'b1, 2'(`PS2_ADR_KBD), b, rd);
			kbd_q.push_back(b);
		end else begin
			wb_cycle(1'b1, 2'(`PS2_ADR_MOUSE), b, rd);
			mouse_q.push_back(b);
		end
	endtask

	task automatic check_status(input ps2_status_t want);
		ps2_byte_t rd;
		wb_cycle(1'b0, 2'(`PS2_ADR_STATUS), 8'h00, rd);
		expect_byte("wb_rsp.dat status", rd, want);
	endtask

	task automatic check_lines_idle();
		expect_bit("ps2_kbd_clk", ps2_kbd_clk, 1'b1);
		expect_bit("ps2_kbd_data", ps2_kbd_data, 1'b1);
		expect_bit("ps2_mouse_clk", ps2_mouse_clk, 1'b1);
		expect_bit("ps2_mouse_data", ps2_mouse_data, 1'b1);
		expect_bit("wb_rsp.ack", wb_rsp.ack, 1'b0);
	endtask

	task automatic wait_drained();
		while (kbd_q.size() != 0 || mouse_q.size() != 0)
			@(negedge ps2_clk);
	endtask

	// no further frame may start once the queues are empty
	task automatic settle_idle();
		while (!(ps2_kbd_clk && ps2_mouse_clk))
			@(negedge ps2_clk);
		repeat (2 * LINE_CYC) begin
			@(negedge ps2_clk);
			check_lines_idle();
		end
	endtask

	// each decoded byte against the oldest written one
	always @(kbd_frames) begin : kbd_check
		ps2_byte_t want;
		if (kbd_frames > 0) begin
			assert (kbd_q.size() > 0) else fail_note("keyboard frame arrived with no byte written");
			want = kbd_q.pop_front();
			expect_byte("ps2_kbd_data byte", kbd_byte, want);
		end
	end

	always @(mouse_frames) begin : mouse_check
		ps2_byte_t want;
		if (mouse_frames > 0) begin
			assert (mouse_q.size() > 0) else fail_note("mouse frame arrived with no byte written");
			want = mouse_q.pop_front();
			expect_byte("ps2_mouse_data byte", mouse_byte, want);
		end
	end

	// frame format errors come from the monitors
	always @(posedge kbd_err or posedge mouse_err)
		fail_run();

	initial begin : stimulus
		ps2_byte_t rd;
		realtime   t0;
		int        i;
		wb_req = '0;
		lfsr   = SEED;
		while (SPI_SS_IO !== 1'b0)
			@(negedge ps2_clk);

		// lines quiet after reset
		repeat (2 * LINE_CYC) begin
			@(negedge ps2_clk);
			check_lines_idle();
		end

		// unused address reads zero and ignores writes
		wb_cycle(1'b0, 2'd3, 8'h00, rd);
		expect_byte("wb_rsp.dat unused address", rd, 8'h00);
		wb_cycle(1'b1, 2'd3, next_byte(), rd);
		check_status(make_status(1'b1, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0));

		// single keyboard byte, exactly one frame
		send_byte(1'b1);
		wait_drained();
		settle_idle();

		// interleaved channels, both lines busy at once
		t0 = $realtime;
		for (i = 0; i < 4; i++) begin
			send_byte(1'b1);
			send_byte(1'b0);
		end
		wait_drained();
		assert ($realtime - t0 < 6 * 12 * BIT_NS) else
			fail_note("keyboard and mouse frames were sent one after the other");
		settle_idle();

		// lead byte holds the transmitter busy while the burst fills the fifo
		send_byte(1'b1);
		while (ps2_kbd_clk)
			@(negedge ps2_clk);
		for (i = 0; i < FIFO_DEPTH + 2; i++) begin
			if (i < FIFO_DEPTH)
				send_byte(1'b1);
			else
				wb_cycle(1'b1, 2'(`PS2_ADR_KBD), next_byte(), rd);
		end

		// overflow seen once, then cleared by the read
		check_status(make_status(1'b0, 1'b1, 1'b1, 1'b1, 1'b0, 1'b0));
		check_status(make_status(1'b0, 1'b1, 1'b0, 1'b1, 1'b0, 1'b0));
		wait_drained();
		settle_idle();
		check_status(make_status(1'b1, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0));

		if (kbd_err || mouse_err)
			fail_run();
		else begin
			$display("=== PASS ===");
			$finish;
		end
	end

	initial begin : watchdog
		#(WATCHDOG_NS);
		$display("watchdog expired after %0d ns before all frames arrived", WATCHDOG_NS);
		fail_run();
	end

endmodule

// ==== sources.f ====
+incdir+hw
hw/ps2_emu_pkg.sv
hw/ps2_byte_fifo.sv
hw/ps2_bit_timer.sv
hw/ps2_frame_fsm.sv
hw/ps2_wb_regs.sv
hw/ps2_emu_top.sv
tb/ps2_clk_gen.sv
tb/ps2_frame_monitor.sv
tb/ps2_emu_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the ps2 emulation testbench with verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert -f sources.f --top-module ps2_emu_tb \
	-Mdir "$OBJ" -o ps2_emu_sim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

"./$OBJ/ps2_emu_sim" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
	echo "simulation exited with status $sim_status"
	exit 1
fi

if grep -q "^=== PASS ===$" "$LOG"; then
	exit 0
fi
echo "pass line not found in $LOG"
exit 1
